// ==== rtl/core_config.svh ====
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// first fetch address out of reset
`define CORE_RESET_PC 32'h0000_0000

// RV32E register file
`define CORE_NREGS 16

`define CORE_RIDX_W 4

`endif

// ==== rtl/core_pkg.sv ====
`include "core_config.svh"

package core_pkg;

    // major instruction class, unsupported encodings land on OP_NOP
    typedef enum logic [3:0] {
        OP_ALU,
        OP_ALUI,
        OP_LUI,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_JAL,
        OP_JALR,
        OP_NOP
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef struct packed {
        opcode_e                 op;
        alu_op_e                 alu;
        logic [`CORE_RIDX_W-1:0] rs1;
        logic [`CORE_RIDX_W-1:0] rs2;
        logic [`CORE_RIDX_W-1:0] rd;
        logic [31:0]             imm;
        logic                    wb_en;
        // branch on not-equal
        logic                    br_ne;
    } dec_t;

    // one access on the shared memory port
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } mem_req_t;

endpackage

// ==== rtl/fetch_unit.sv ====
module fetch_unit (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_go,
    input  logic [31:0] pc,
    output logic        if_go,
    input  logic        if_done,
    input  logic [31:0] if_rdata,
    output logic [31:0] inst,
    output logic        inst_valid
);

    // addi x0, x0, 0
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

    logic busy;

    // one fetch outstanding at a time
    assign if_go = fetch_go & ~busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy       <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= busy & if_done;
            if (if_go) begin
                busy <= 1'b1;
            end else if (if_done) begin
                busy <= 1'b0;
            end
        end
    end

    // misaligned pc degrades to a nop, there are no traps
    always_ff @(posedge clk) begin
        if (busy && if_done) begin
            inst <= (pc[1:0] == 2'b00) ? if_rdata : NOP_WORD;
        end
    end

endmodule

// ==== rtl/decode_unit.sv ====
module decode_unit (
    input  logic [31:0]       inst,
    output core_pkg::dec_t    dec
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'h000};
    assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        // upper index bit is dropped, RV32E has 16 registers
        dec.op    = core_pkg::OP_NOP;
        dec.alu   = core_pkg::ALU_ADD;
        dec.rs1   = inst[18:15];
        dec.rs2   = inst[23:20];
        dec.rd    = inst[10:7];
        dec.imm   = 32'h0;
        dec.wb_en = 1'b0;
        dec.br_ne = funct3[0];

        case (opcode)
            7'b0110011: begin
                dec.wb_en = 1'b1;
                dec.op    = core_pkg::OP_ALU;
                case (funct3)
                    3'b000: begin
                        if (funct7 == 7'b0100000) begin
                            dec.alu = core_pkg::ALU_SUB;
                        end else if (funct7 != 7'b0000000) begin
                            dec.op    = core_pkg::OP_NOP;
                            dec.wb_en = 1'b0;
                        end
                    end
                    3'b111: dec.alu = core_pkg::ALU_AND;
                    3'b110: dec.alu = core_pkg::ALU_OR;
                    3'b100: dec.alu = core_pkg::ALU_XOR;
                    3'b010: dec.alu = core_pkg::ALU_SLT;
                    default: begin
                        dec.op    = core_pkg::OP_NOP;
                        dec.wb_en = 1'b0;
                    end
                endcase
            end
            7'b0010011: begin
                dec.imm   = imm_i;
                dec.wb_en = 1'b1;
                dec.op    = core_pkg::OP_ALUI;
                case (funct3)
                    3'b000: dec.alu = core_pkg::ALU_ADD;
                    3'b111: dec.alu = core_pkg::ALU_AND;
                    3'b110: dec.alu = core_pkg::ALU_OR;
                    3'b100: dec.alu = core_pkg::ALU_XOR;
                    default: begin
                        dec.op    = core_pkg::OP_NOP;
                        dec.wb_en = 1'b0;
                    end
                endcase
            end
            7'b0110111: begin
                dec.op    = core_pkg::OP_LUI;
                dec.imm   = imm_u;
                dec.wb_en = 1'b1;
            end
            7'b0000011: begin
                if (funct3 == 3'b010) begin
                    dec.op    = core_pkg::OP_LOAD;
                    dec.imm   = imm_i;
                    dec.wb_en = 1'b1;
                end
            end
            7'b0100011: begin
                if (funct3 == 3'b010) begin
                    dec.op  = core_pkg::OP_STORE;
                    dec.imm = imm_s;
                end
            end
            7'b1100011: begin
                // beq and bne only
                if (funct3[2:1] == 2'b00) begin
                    dec.op  = core_pkg::OP_BRANCH;
                    dec.imm = imm_b;
                end
            end
            7'b1101111: begin
                dec.op    = core_pkg::OP_JAL;
                dec.imm   = imm_j;
                dec.wb_en = 1'b1;
            end
            7'b1100111: begin
                dec.op    = core_pkg::OP_JALR;
                dec.imm   = imm_i;
                dec.wb_en = 1'b1;
            end
            default: dec.op = core_pkg::OP_NOP;
        endcase
    end

endmodule

// ==== rtl/reg_file.sv ====
`include "core_config.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    we,
    input  logic [`CORE_RIDX_W-1:0] waddr,
    input  logic [31:0]             wdata,
    input  logic [`CORE_RIDX_W-1:0] raddr1,
    input  logic [`CORE_RIDX_W-1:0] raddr2,
    output logic [31:0]             rdata1,
    output logic [31:0]             rdata2
);

    // x0 has no storage
    logic [31:0] regs [1:`CORE_NREGS-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < `CORE_NREGS; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? 32'h0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? 32'h0 : regs[raddr2];

endmodule

// ==== rtl/exec_unit.sv ====
module exec_unit (
    input  core_pkg::dec_t dec,
    input  logic [31:0]    pc,
    input  logic [31:0]    rs1_d,
    input  logic [31:0]    rs2_d,
    output logic [31:0]    result,
    output logic           taken,
    output logic [31:0]    target
);

    logic [31:0] alu_b;
    logic [31:0] alu_out;
    logic [31:0] sum_ri;
    logic [31:0] pc_next;

    assign alu_b   = (dec.op == core_pkg::OP_ALU) ? rs2_d : dec.imm;
    // load/store address and jalr base
    assign sum_ri  = rs1_d + dec.imm;
    assign pc_next = pc + 32'd4;

    always_comb begin
        case (dec.alu)
            core_pkg::ALU_SUB: alu_out = rs1_d - alu_b;
            core_pkg::ALU_AND: alu_out = rs1_d & alu_b;
            core_pkg::ALU_OR:  alu_out = rs1_d | alu_b;
            core_pkg::ALU_XOR: alu_out = rs1_d ^ alu_b;
            core_pkg::ALU_SLT: alu_out = {31'h0, $signed(rs1_d) < $signed(alu_b)};
            default:           alu_out = rs1_d + alu_b;
        endcase
    end

    always_comb begin
        case (dec.op)
            core_pkg::OP_ALU, core_pkg::OP_ALUI: result = alu_out;
            core_pkg::OP_LUI:                    result = dec.imm;
            core_pkg::OP_JAL, core_pkg::OP_JALR: result = pc_next;
            core_pkg::OP_LOAD, core_pkg::OP_STORE: result = sum_ri;
            default:                             result = 32'h0;
        endcase
    end

    // br_ne flips the sense of the equality test
    assign taken = (dec.op == core_pkg::OP_JAL) || (dec.op == core_pkg::OP_JALR) ||
                   ((dec.op == core_pkg::OP_BRANCH) && ((rs1_d == rs2_d) != dec.br_ne));

    assign target = (dec.op == core_pkg::OP_JALR) ? {sum_ri[31:1], 1'b0} : pc + dec.imm;

endmodule

// ==== rtl/lsu.sv ====
module lsu (
    input  logic                clk,
    input  logic                rst,
    input  logic                if_go,
    input  logic [31:0]         pc,
    output logic                if_done,
    input  logic                mem_go,
    input  core_pkg::dec_t      dec,
    input  logic [31:0]         addr,
    input  logic [31:0]         wdata,
    output logic                data_done,
    output logic [31:0]         rdata_q,
    output core_pkg::mem_req_t  mem_req,
    output logic                req,
    input  logic                ack,
    input  logic [31:0]         rdata
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_HI,
        S_WAIT_LO,
        S_DONE
    } state_e;

    state_e             state;
    logic               is_data;
    logic               start;
    core_pkg::mem_req_t next_req;

    assign start = (state == S_IDLE) && (if_go || mem_go);

    // fetch and data never start together
    always_comb begin
        if (mem_go) begin
            next_req.addr  = addr;
            next_req.wdata = wdata;
            next_req.we    = (dec.op == core_pkg::OP_STORE);
        end else begin
            next_req.addr  = pc;
            next_req.wdata = 32'h0;
            next_req.we    = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= S_IDLE;
            req     <= 1'b0;
            is_data <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state   <= S_WAIT_HI;
                        req     <= 1'b1;
                        is_data <= mem_go;
                    end
                end
                S_WAIT_HI: begin
                    if (ack) begin
                        state <= S_WAIT_LO;
                        req   <= 1'b0;
                    end
                end
                S_WAIT_LO: begin
                    if (!ack) begin
                        state <= S_DONE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // request held stable for the whole handshake
    always_ff @(posedge clk) begin
        if (start) begin
            mem_req <= next_req;
        end
        if (state == S_WAIT_HI && ack) begin
            rdata_q <= rdata;
        end
    end

    assign if_done   = (state == S_DONE) && !is_data;
    assign data_done = (state == S_DONE) && is_data;

endmodule

// ==== rtl/pc_unit.sv ====
`include "core_config.svh"

module pc_unit (
    input  logic           clk,
    input  logic           rst,
    input  logic           inst_valid,
    input  core_pkg::dec_t dec,
    input  logic           data_done,
    input  logic           taken,
    input  logic [31:0]    target,
    output logic           fetch_go,
    output logic           mem_go,
    output logic           commit,
    output logic [31:0]    pc
);

    logic is_mem;
    logic commit_q;

    assign is_mem = (dec.op == core_pkg::OP_LOAD) || (dec.op == core_pkg::OP_STORE);

    // memory ops commit on data_done, others a cycle after decode
    assign commit = commit_q | data_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= `CORE_RESET_PC;
            // first fetch leaves as soon as reset drops
            fetch_go <= 1'b1;
            mem_go   <= 1'b0;
            commit_q <= 1'b0;
        end else begin
            fetch_go <= commit;
            mem_go   <= inst_valid & is_mem;
            commit_q <= inst_valid & ~is_mem;
            if (commit) begin
                pc <= taken ? target : pc + 32'd4;
            end
        end
    end

endmodule

// ==== rtl/core_top.sv ====
module core_top (
    input  logic               clk,
    input  logic               rst,
    output core_pkg::mem_req_t mem_req,
    output logic               req,
    input  logic               ack,
    input  logic [31:0]        rdata
);

    logic [31:0]    pc;
    logic           fetch_go;
    logic           if_go;
    logic           if_done;
    logic [31:0]    rdata_q;
    logic [31:0]    inst;
    logic           inst_valid;
    core_pkg::dec_t dec;
    logic [31:0]    rs1_d;
    logic [31:0]    rs2_d;
    logic [31:0]    result;
    logic           taken;
    logic [31:0]    target;
    logic           mem_go;
    logic           data_done;
    logic           commit;
    logic           rf_we;
    logic [31:0]    rf_wdata;

    // write back at commit, loads take the memory word
    assign rf_we    = dec.wb_en & commit;
    assign rf_wdata = (dec.op == core_pkg::OP_LOAD) ? rdata_q : result;

    fetch_unit u_fetch (
        .clk        (clk),
        .rst        (rst),
        .fetch_go   (fetch_go),
        .pc         (pc),
        .if_go      (if_go),
        .if_done    (if_done),
        .if_rdata   (rdata_q),
        .inst       (inst),
        .inst_valid (inst_valid)
    );

    decode_unit u_decode (
        .inst (inst),
        .dec  (dec)
    );

    reg_file u_regs (
        .clk    (clk),
        .rst    (rst),
        .we     (rf_we),
        .waddr  (dec.rd),
        .wdata  (rf_wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_d),
        .rdata2 (rs2_d)
    );

    exec_unit u_exec (
        .dec    (dec),
        .pc     (pc),
        .rs1_d  (rs1_d),
        .rs2_d  (rs2_d),
        .result (result),
        .taken  (taken),
        .target (target)
    );

    lsu u_lsu (
        .clk       (clk),
        .rst       (rst),
        .if_go     (if_go),
        .pc        (pc),
        .if_done   (if_done),
        .mem_go    (mem_go),
        .dec       (dec),
        .addr      (result),
        .wdata     (rs2_d),
        .data_done (data_done),
        .rdata_q   (rdata_q),
        .mem_req   (mem_req),
        .req       (req),
        .ack       (ack),
        .rdata     (rdata)
    );

    pc_unit u_pc (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .dec        (dec),
        .data_done  (data_done),
        .taken      (taken),
        .target     (target),
        .fetch_go   (fetch_go),
        .mem_go     (mem_go),
        .commit     (commit),
        .pc         (pc)
    );

endmodule

// ==== tests/core_tb.sv ====
`include "core_config.svh"

module core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int K_ALU    = 0;
    localparam int K_ALUI   = 1;
    localparam int K_LUI    = 2;
    localparam int K_LOAD   = 3;
    localparam int K_STORE  = 4;
    localparam int K_BRANCH = 5;
    localparam int K_JAL    = 6;
    localparam int K_JALR   = 7;

    localparam int F_ADD = 0;
    localparam int F_SUB = 1;
    localparam int F_AND = 2;
    localparam int F_OR  = 3;
    localparam int F_XOR = 4;
    localparam int F_SLT = 5;

    localparam logic [31:0] FINAL_PC = 32'd252;
    // 64 instructions, 2 accesses each, 20 cycles per access, plus reset
    localparam int TIMEOUT_NS = 64 * 2 * 20 * 40 + 16 * 40;

    logic               clk;
    logic               rst;
    core_pkg::mem_req_t mem_req;
    logic               req;
    logic               ack;
    logic [31:0]        rdata;

    integer seed = 96;
    int     final_hits = 0;

    // words 0..63 program, 128..191 data region
    logic [31:0] mem [0:255];

    // program record for the ISA model
    int          p_kind [64];
    int          p_fn   [64];
    int          p_rd   [64];
    int          p_rs1  [64];
    int          p_rs2  [64];
    logic [31:0] p_imm  [64];

    logic [31:0]        model_pc;
    logic [31:0]        mregs [16];
    logic [31:0]        model_mem [0:255];
    core_pkg::mem_req_t exp_data;
    logic               data_pending = 1'b0;

    core_top u_dut (
        .clk     (clk),
        .rst     (rst),
        .mem_req (mem_req),
        .req     (req),
        .ack     (ack),
        .rdata   (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        rand_below = $unsigned($random(seed)) % n;
    endfunction

    function automatic logic [2:0] alu_funct3(input int fn);
        case (fn)
            F_AND:   alu_funct3 = 3'b111;
            F_OR:    alu_funct3 = 3'b110;
            F_XOR:   alu_funct3 = 3'b100;
            F_SLT:   alu_funct3 = 3'b010;
            default: alu_funct3 = 3'b000;
        endcase
    endfunction

    // RV32I base encodings
    function automatic logic [31:0] encode(input int kind, input int fn, input logic [4:0] rd,
            input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
        logic [2:0] f3;
        f3 = alu_funct3(fn);
        case (kind)
            K_ALU:    encode = {(fn == F_SUB) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011};
            K_ALUI:   encode = {imm[11:0], rs1, f3, rd, 7'b0010011};
            K_LUI:    encode = {imm[31:12], rd, 7'b0110111};
            K_LOAD:   encode = {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
            K_STORE:  encode = {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
            K_BRANCH: encode = {imm[12], imm[10:5], rs2, rs1, 2'b00, fn[0], imm[4:1], imm[11],
                                7'b1100011};
            K_JAL:    encode = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
            default:  encode = {imm[11:0], rs1, 3'b000, rd, 7'b1100111};
        endcase
    endfunction

    task automatic place(input int idx, input int kind, input int fn, input int rd,
            input int rs1, input int rs2, input logic [31:0] imm);
        p_kind[idx] = kind;
        p_fn[idx]   = fn;
        p_rd[idx]   = rd;
        p_rs1[idx]  = rs1;
        p_rs2[idx]  = rs2;
        p_imm[idx]  = imm;
        mem[idx]    = encode(kind, fn, rd[4:0], rs1[4:0], rs2[4:0], imm);
    endtask

    task automatic build_program();
        int          i;
        int          k;
        int          rd;
        int          fn;
        int          off;
        logic [31:0] rnd;
        // words that some jump or branch lands on
        bit          landed [64];
        for (i = 0; i < 64; i++) begin
            landed[i] = 1'b0;
        end
        for (i = 0; i < 256; i++) begin
            mem[i] = $random(seed);
        end
        // x15 is the data base, x14 the jalr target
        place(0, K_ALUI, F_ADD, 15, 0, 0, 32'h200);
        i = 1;
        while (i < 63) begin
            k   = rand_below(10);
            rd  = rand_below(14);
            rnd = $random(seed);
            off = 1 + rand_below(4);
            if (off > 63 - i) begin
                off = 63 - i;
            end
            // a jalr is only ever entered through its addi
            if (k == 7 && i < 62 && !landed[i + 1]) begin
                off = i + 2 + rand_below(4);
                if (off > 63) begin
                    off = 63;
                end
                place(i, K_ALUI, F_ADD, 14, 0, 0, off * 4);
                place(i + 1, K_JALR, F_ADD, rd, 14, 0, 32'h0);
                landed[off] = 1'b1;
                i = i + 2;
            end else begin
                case (k)
                    1: begin
                        fn = rand_below(4);
                        fn = (fn == 0) ? F_ADD : fn + 1;
                        place(i, K_ALUI, fn, rd, rand_below(16), 0, {{20{rnd[11]}}, rnd[11:0]});
                    end
                    2: place(i, K_LUI, F_ADD, rd, 0, 0, {rnd[31:12], 12'h000});
                    3: place(i, K_LOAD, F_ADD, rd, 15, 0, rand_below(64) * 4);
                    4, 8, 9: place(i, K_STORE, F_ADD, 0, 15, rand_below(16), rand_below(64) * 4);
                    5: begin
                        place(i, K_BRANCH, rand_below(2), 0, rand_below(16), rand_below(16),
                              off * 4);
                        landed[i + off] = 1'b1;
                    end
                    6: begin
                        place(i, K_JAL, F_ADD, rd, 0, 0, off * 4);
                        landed[i + off] = 1'b1;
                    end
                    default: place(i, K_ALU, rand_below(6), rd, rand_below(16), rand_below(16),
                                   32'h0);
                endcase
                i = i + 1;
            end
        end
        place(63, K_JAL, F_ADD, 0, 0, 0, 32'h0);
        for (i = 0; i < 256; i++) begin
            model_mem[i] = mem[i];
        end
    endtask

    function automatic logic [31:0] model_alu(input int fn, input logic [31:0] a,
            input logic [31:0] b);
        case (fn)
            F_SUB:   model_alu = a - b;
            F_AND:   model_alu = a & b;
            F_OR:    model_alu = a | b;
            F_XOR:   model_alu = a ^ b;
            F_SLT:   model_alu = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: model_alu = a + b;
        endcase
    endfunction

    task automatic write_reg(input int r, input logic [31:0] v);
        if (r != 0) begin
            mregs[r] = v;
        end
    endtask

    // one instruction of the ISA model
    task automatic step_model();
        int          idx;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ea;
        logic [31:0] next_pc;
        idx     = model_pc[7:2];
        a       = mregs[p_rs1[idx]];
        b       = mregs[p_rs2[idx]];
        ea      = a + p_imm[idx];
        next_pc = model_pc + 32'd4;
        case (p_kind[idx])
            K_ALU:  write_reg(p_rd[idx], model_alu(p_fn[idx], a, b));
            K_ALUI: write_reg(p_rd[idx], model_alu(p_fn[idx], a, p_imm[idx]));
            K_LUI:  write_reg(p_rd[idx], p_imm[idx]);
            K_LOAD: begin
                exp_data.addr  = ea;
                exp_data.wdata = 32'h0;
                exp_data.we    = 1'b0;
                data_pending   = 1'b1;
                write_reg(p_rd[idx], model_mem[ea[9:2]]);
            end
            K_STORE: begin
                exp_data.addr  = ea;
                exp_data.wdata = b;
                exp_data.we    = 1'b1;
                data_pending   = 1'b1;
                model_mem[ea[9:2]] = b;
            end
            K_BRANCH: begin
                if ((p_fn[idx] == 1) ? (a != b) : (a == b)) begin
                    next_pc = model_pc + p_imm[idx];
                end
            end
            K_JAL: begin
                write_reg(p_rd[idx], model_pc + 32'd4);
                next_pc = model_pc + p_imm[idx];
            end
            default: begin
                write_reg(p_rd[idx], model_pc + 32'd4);
                next_pc = ea & ~32'h1;
            end
        endcase
        model_pc = next_pc;
    endtask

    task automatic fail_now();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_fetch(input core_pkg::mem_req_t got);
        if (got.addr !== model_pc || got.we !== 1'b0) begin
            $display("Error at %0t ns: fetch expected addr %h we 0, got addr %h we %b",
                     $time, model_pc, got.addr, got.we);
            fail_now();
        end
    endtask

    task automatic check_load(input core_pkg::mem_req_t got);
        if (got.addr !== exp_data.addr || got.we !== 1'b0) begin
            $display("Error at %0t ns: load expected addr %h we 0, got addr %h we %b",
                     $time, exp_data.addr, got.addr, got.we);
            fail_now();
        end
    endtask

    task automatic check_store(input core_pkg::mem_req_t got);
        if (got !== exp_data) begin
            $display("Error at %0t ns: store expected %h/%h/%b, got %h/%h/%b", $time,
                     exp_data.addr, exp_data.wdata, exp_data.we, got.addr, got.wdata, got.we);
            fail_now();
        end
    endtask

    task automatic check_request(input core_pkg::mem_req_t got);
        if (data_pending) begin
            data_pending = 1'b0;
            if (exp_data.we) begin
                check_store(got);
            end else begin
                check_load(got);
            end
        end else begin
            check_fetch(got);
            if (model_pc == FINAL_PC) begin
                final_hits = final_hits + 1;
            end
            step_model();
        end
    endtask

    // four-phase memory responder with random delays
    task automatic answer_request();
        core_pkg::mem_req_t held;
        int                 delay;
        held = mem_req;
        check_request(held);
        delay = rand_below(6);
        repeat (delay) begin
            @(negedge clk);
            if (req !== 1'b1 || mem_req !== held) begin
                $display("Error at %0t ns: req dropped or mem_req changed before ack", $time);
                fail_now();
            end
        end
        if (held.we) begin
            mem[held.addr[9:2]] = held.wdata;
        end else begin
            rdata = mem[held.addr[9:2]];
        end
        ack = 1'b1;
        @(negedge clk);
        while (req === 1'b1) begin
            if (mem_req !== held) begin
                $display("Error at %0t ns: mem_req changed while req was high", $time);
                fail_now();
            end
            @(negedge clk);
        end
        delay = rand_below(6);
        repeat (delay) begin
            @(negedge clk);
            if (req === 1'b1) begin
                $display("Error at %0t ns: new req raised while ack was still high", $time);
                fail_now();
            end
        end
        ack   = 1'b0;
        rdata = 32'h0;
    endtask

    initial begin
        forever begin
            @(negedge clk);
            if (req === 1'b1) begin
                answer_request();
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the core stopped fetching before the end of the program");
        fail_now();
    end

    initial begin
        rst   = 1'b1;
        ack   = 1'b0;
        rdata = 32'h0;
        build_program();
        model_pc = `CORE_RESET_PC;
        for (int r = 0; r < 16; r++) begin
            mregs[r] = 32'h0;
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        if (req !== 1'b0) begin
            $display("Error at %0t ns: req is not low after reset", $time);
            fail_now();
        end
        wait (final_hits == 2);
        @(negedge clk);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/core_pkg.sv
rtl/fetch_unit.sv
rtl/decode_unit.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/lsu.sv
rtl/pc_unit.sv
rtl/core_top.sv
tests/core_tb.sv
